/* Bender.yml */
package:
  name: systolic_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/systolic_pkg.sv
      - hdl/array_ctrl_if.sv
      - hdl/seq_mac.sv
      - hdl/processing_element.sv
      - hdl/systolic_pe_matrix.sv
      - hdl/operand_skewer.sv
      - hdl/mat_mul_sequencer.sv
      - hdl/systolic_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_systolic_top.sv

/* compile.f */
+incdir+hdl
hdl/systolic_pkg.sv
hdl/array_ctrl_if.sv
hdl/seq_mac.sv
hdl/processing_element.sv
hdl/systolic_pe_matrix.sv
hdl/operand_skewer.sv
hdl/mat_mul_sequencer.sv
hdl/systolic_top.sv
tests/tb_systolic_top.sv

/* hdl/array_ctrl_if.sv */
// control strobes and operand lanes passed from the sequencer and skewer into the PE grid
interface array_ctrl_if;
  import systolic_pkg::*;

  op_t       op;            // latched at i_start
  logic      clear;         // one cycle after i_start
  logic      eltwise_ready; // element operands in place, shifting stops
  lane_vec_t a_lanes;       // row lanes into column 0
  lane_vec_t b_lanes;       // column lanes into row 0

  modport seq (
    output op,
    output clear,
    output eltwise_ready
  );

  modport skew (
    input  op,
    output a_lanes,
    output b_lanes
  );

  modport grid (
    input op,
    input clear,
    input eltwise_ready,
    input a_lanes,
    input b_lanes
  );

endinterface

/* hdl/mat_mul_sequencer.sv */
// run control for the grid, latches op, pulses clear, counts load steps and times o_done
`include "systolic_defs.svh"

module mat_mul_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  input  systolic_pkg::op_t i_op,
  input  logic              i_valid,
  output logic              o_done,
  array_ctrl_if.seq         ctrl
);
  import systolic_pkg::*;

  localparam int STEP_W = $clog2(`ARRAY_SIZE + 1);
  localparam int LAT_W  = $clog2(`DONE_LATENCY + 1);

  logic              busy;     // start seen, done not yet
  logic [STEP_W-1:0] step_cnt;
  logic [LAT_W-1:0]  lat_cnt;  // counts down to o_done
  logic              take_step;
  logic              last_step;

  assign take_step = i_valid && busy && (step_cnt != STEP_W'(`ARRAY_SIZE));
  assign last_step = take_step && (step_cnt == STEP_W'(`ARRAY_SIZE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl.op            <= OP_MAT_MUL;
      ctrl.clear         <= 1'b0;
      ctrl.eltwise_ready <= 1'b0;
      busy               <= 1'b0;
      step_cnt           <= '0;
      lat_cnt            <= '0;
      o_done             <= 1'b0;
    end else begin
      ctrl.clear <= i_start;
      o_done     <= (lat_cnt == LAT_W'(1));
      if (lat_cnt != '0)
        lat_cnt <= lat_cnt - 1'b1;

      if (i_start) begin
        ctrl.op            <= i_op;
        ctrl.eltwise_ready <= 1'b0; // releases the previous element result
        busy               <= 1'b1;
        step_cnt           <= '0;
      end else begin
        if (take_step)
          step_cnt <= step_cnt + 1'b1;
        if (last_step) begin
          lat_cnt <= LAT_W'(`DONE_LATENCY);
          // held past o_done so element results stay on o_result
          if (ctrl.op != OP_MAT_MUL)
            ctrl.eltwise_ready <= 1'b1;
        end
        if (lat_cnt == LAT_W'(1))
          busy <= 1'b0;
      end
    end
  end

  a_valid_count: assert property (@(posedge clk) disable iff (reset)
    i_valid |-> (step_cnt < STEP_W'(`ARRAY_SIZE)))
    else $error("more than ARRAY_SIZE valid steps in one operation");

  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    i_start |-> !busy)
    else $error("i_start while a run is still active");

endmodule

/* hdl/operand_skewer.sv */
// staggers lane k by k cycles for matrix multiply, passes lanes straight for element ops
`include "systolic_defs.svh"

module operand_skewer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_valid,
  input  systolic_pkg::lane_vec_t i_a_lanes,
  input  systolic_pkg::lane_vec_t i_b_lanes,
  array_ctrl_if.skew              ctrl
);
  import systolic_pkg::*;

  localparam int N = `ARRAY_SIZE;

  lane_vec_t a_gated;
  lane_vec_t b_gated;
  lane_vec_t a_skewed;
  lane_vec_t b_skewed;

  assign a_gated = i_valid ? i_a_lanes : '0; // zeros between load windows
  assign b_gated = i_valid ? i_b_lanes : '0;

  for (genvar k = 0; k < N; k++) begin : g_lane
    if (k == 0) begin : g_direct
      assign a_skewed[k] = a_gated[k];
      assign b_skewed[k] = b_gated[k];
    end else begin : g_delay
      word_t a_dly [k];
      word_t b_dly [k];

      always_ff @(posedge clk) begin
        if (reset) begin
          a_dly <= '{default: '0};
          b_dly <= '{default: '0};
        end else begin
          a_dly[0] <= a_gated[k];
          b_dly[0] <= b_gated[k];
          for (int d = 1; d < k; d++) begin
            a_dly[d] <= a_dly[d-1];
            b_dly[d] <= b_dly[d-1];
          end
        end
      end

      assign a_skewed[k] = a_dly[k-1];
      assign b_skewed[k] = b_dly[k-1];
    end
  end

  // element ops need every lane to land in the same cycle
  assign ctrl.a_lanes = (ctrl.op == OP_MAT_MUL) ? a_skewed : a_gated;
  assign ctrl.b_lanes = (ctrl.op == OP_MAT_MUL) ? b_skewed : b_gated;

endmodule

/* hdl/processing_element.sv */
// one grid cell, passes A right and B down and runs its MAC on the pair it holds
module processing_element (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  systolic_pkg::op_t   i_op,
  input  logic                i_eltwise_ready,
  input  systolic_pkg::word_t i_a,
  input  systolic_pkg::word_t i_b,
  output systolic_pkg::word_t o_a,
  output systolic_pkg::word_t o_b,
  output systolic_pkg::word_t o_c
);
  import systolic_pkg::*;

  logic elt_mode;
  logic hold;
  logic mac_reset;

  assign elt_mode = (i_op != OP_MAT_MUL);
  assign hold     = elt_mode && i_eltwise_ready; // element operands have landed

  // mac stays cleared while element operands are still shifting in
  assign mac_reset = reset || i_clear || (elt_mode && !i_eltwise_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else if (!hold) begin
      o_a <= i_a; // one register per hop
      o_b <= i_b;
    end
  end

  // mac works on the registered pair, which is what the cell holds in element mode
  seq_mac u_mac (
    .clk   (clk),
    .reset (mac_reset),
    .i_op  (i_op),
    .i_a   (o_a),
    .i_b   (o_b),
    .o_out (o_c)
  );

endmodule

/* hdl/seq_mac.sv */
// three-stage signed MAC and element add/sub/mul with saturation to one word, one per PE
`include "systolic_defs.svh"

module seq_mac (
  input  logic                clk,
  input  logic                reset,
  input  systolic_pkg::op_t   i_op,
  input  systolic_pkg::word_t i_a,
  input  systolic_pkg::word_t i_b,
  output systolic_pkg::word_t o_out
);
  import systolic_pkg::*;

  word_t                        a_q;
  word_t                        b_q;
  logic signed [`ACC_WIDTH-1:0] acc;
  logic signed [`ACC_WIDTH-1:0] acc_next;
  logic signed [`ACC_WIDTH-1:0] prod;
  logic signed [`ACC_WIDTH:0]   mac_sum; // one guard bit for the running sum

  // clamp a wide value into the signed word range
  function automatic word_t sat_word(input logic signed [`ACC_WIDTH-1:0] value);
    logic [`ACC_WIDTH-`DWIDTH:0] upper;
    upper = value[`ACC_WIDTH-1:`DWIDTH-1];
    if ((&upper) || !(|upper))
      return value[`DWIDTH-1:0]; // fits, upper bits are pure sign
    else if (value[`ACC_WIDTH-1])
      return {1'b1, {(`DWIDTH-1){1'b0}}};
    else
      return {1'b0, {(`DWIDTH-1){1'b1}}};
  endfunction

  always_comb begin
    prod    = a_q * b_q;
    mac_sum = acc + prod;
    case (i_op)
      OP_MAT_MUL: begin
        // the sum itself saturates so large inner products cannot wrap
        if (mac_sum[`ACC_WIDTH] != mac_sum[`ACC_WIDTH-1])
          acc_next = {mac_sum[`ACC_WIDTH], {(`ACC_WIDTH-1){~mac_sum[`ACC_WIDTH]}}};
        else
          acc_next = mac_sum[`ACC_WIDTH-1:0];
      end
      OP_ELT_MUL: acc_next = prod;
      OP_ELT_ADD: acc_next = a_q + b_q;
      default:    acc_next = a_q - b_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_q   <= '0;
      b_q   <= '0;
      acc   <= '0;
      o_out <= '0;
    end else begin
      a_q   <= i_a;          // stage 1
      b_q   <= i_b;
      acc   <= acc_next;     // stage 2
      o_out <= sat_word(acc); // stage 3
    end
  end

  // a new op is only latched while the grid holds every MAC in clear
  a_op_stable: assert property (@(posedge clk) disable iff (reset) $stable(i_op))
    else $error("seq_mac op changed outside a MAC reset");

endmodule

/* hdl/systolic_defs.svh */
// word, grid and latency sizes for the systolic engine, included by the RTL and the testbench
`ifndef SYSTOLIC_DEFS_SVH
`define SYSTOLIC_DEFS_SVH

// operand and result word width
`define DWIDTH 16

// rows and columns of the grid, also the load steps per operation
`define ARRAY_SIZE 4

// accumulator width inside each MAC
`define ACC_WIDTH 32

// cycles from the edge that samples the last i_valid to o_done
`define DONE_LATENCY 10

`endif

/* hdl/systolic_pe_matrix.sv */
// square grid of PEs with A chains along rows and B chains down columns, results packed row-major
`include "systolic_defs.svh"

module systolic_pe_matrix (
  input  logic                                               clk,
  input  logic                                               reset,
  array_ctrl_if.grid                                         ctrl,
  output systolic_pkg::word_t [`ARRAY_SIZE*`ARRAY_SIZE-1:0] o_result
);
  import systolic_pkg::*;

  localparam int N = `ARRAY_SIZE;

  word_t a_hop [N][N]; // o_a of each cell
  word_t b_hop [N][N]; // o_b of each cell

  for (genvar r = 0; r < N; r++) begin : g_row
    for (genvar c = 0; c < N; c++) begin : g_col
      word_t a_in;
      word_t b_in;

      // inner hops are flushed on clear so operands frozen by an element op do not leak
      if (c == 0) begin : g_a_edge
        assign a_in = ctrl.a_lanes[r];
      end else begin : g_a_inner
        assign a_in = ctrl.clear ? '0 : a_hop[r][c-1];
      end

      if (r == 0) begin : g_b_edge
        assign b_in = ctrl.b_lanes[c];
      end else begin : g_b_inner
        assign b_in = ctrl.clear ? '0 : b_hop[r-1][c];
      end

      processing_element u_pe (
        .clk             (clk),
        .reset           (reset),
        .i_clear         (ctrl.clear),
        .i_op            (ctrl.op),
        .i_eltwise_ready (ctrl.eltwise_ready),
        .i_a             (a_in),
        .i_b             (b_in),
        .o_a             (a_hop[r][c]),
        .o_b             (b_hop[r][c]),
        .o_c             (o_result[r*N+c]) // C00 in the low word
      );
    end
  end

endmodule

/* hdl/systolic_pkg.sv */
// shared operation code and operand lane types, imported by the sequencer, skewer and grid
`include "systolic_defs.svh"

package systolic_pkg;

  // op[1:0] encoding follows the grid datapath decode
  typedef enum logic [1:0] {
    OP_MAT_MUL = 2'b00,
    OP_ELT_MUL = 2'b01,
    OP_ELT_ADD = 2'b10,
    OP_ELT_SUB = 2'b11
  } op_t;

  typedef logic signed [`DWIDTH-1:0] word_t;

  // one word per row (A) or column (B) lane, lane 0 in the low bits
  typedef word_t [`ARRAY_SIZE-1:0] lane_vec_t;

endpackage

/* hdl/systolic_top.sv */
// top level of the systolic matrix engine with plain ports, wires sequencer, skewer and grid
`include "systolic_defs.svh"

module systolic_top (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      i_start,
  input  logic [1:0]                                i_op,
  input  logic                                      i_valid,
  input  logic [`ARRAY_SIZE*`DWIDTH-1:0]            i_a_lanes, // lane i in bits 16i+15:16i
  input  logic [`ARRAY_SIZE*`DWIDTH-1:0]            i_b_lanes,
  output logic                                      o_done,
  output logic [`ARRAY_SIZE*`ARRAY_SIZE*`DWIDTH-1:0] o_result  // word i*4+j holds C[i][j]
);
  import systolic_pkg::*;

  array_ctrl_if u_ctrl_if ();

  mat_mul_sequencer u_seq (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .i_op    (op_t'(i_op)),
    .i_valid (i_valid),
    .o_done  (o_done),
    .ctrl    (u_ctrl_if)
  );

  operand_skewer u_skew (
    .clk       (clk),
    .reset     (reset),
    .i_valid   (i_valid),
    .i_a_lanes (i_a_lanes),
    .i_b_lanes (i_b_lanes),
    .ctrl      (u_ctrl_if)
  );

  systolic_pe_matrix u_grid (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (u_ctrl_if),
    .o_result (o_result)
  );

endmodule

/* tests/systolic_vectors.txt */
# per test: op (0 mat mul, 1 elt mul, 2 elt add, 3 elt sub), then A lanes of load steps 0..3
# next line B lanes of steps 0..3 (lane 3 leftmost), last line results C00 C01 .. C33
0 0002ffff00050001 fffd000000060002 0000000100070003 0001000200080004 # small matrix multiply
ffff000200000001 0002000100010000 00010000fffe0003 0000ffff00010001
000e 0000 0000 0006 0022 0000 0008 000e 0004 0000 fffc 0002 0003 fffe 0000 fff8
1 00080001fffc0005 00070000fffd0004 fc180190fffe0003 03e8012cffff0002 # element multiply
0002ffff00280028 ffff0005ff9c00c8 0003000300030003 000a000a000a000a
0014 001e 0028 0032 fffd fffa fff7 fff4 7fff 8000 0000 ffff 7fff 8000 fff9 0010
0 00648000b1e04e20 00648000012c4e20 0000800000004e20 0000800000004e20 # saturating matrix
0003800007d00001 0001800000000001 0000800000000001 0000800000000001
7fff 7fff 8000 7fff b30c 8000 7fff 8000 8000 8000 7fff 8000 00c8 7fff 8000 0190
2 00080001fffc0005 00070000fffd0004 fc180190fffe0003 03e8012cffff0002 # element add
0002ffff00280028 ffff0005ff9c00c8 0003000300030003 000a000a000a000a
000c 000d 000e 000f 0002 0001 0000 ffff 01f4 012c 0005 0000 0410 fc40 0006 000a
3 00080001fffc0005 00078000fffd0004 fc180190fffe0003 7530012cffff0002 # element subtract
0002ffff00288ad0 ffff0005ff9c00c8 0003000300030003 000a000a000a000a
fff8 fff9 fffa fffb fffc fffb fffa fff9 0064 01f4 8000 0002 7fff fbf0 0008 0006

/* tests/tb_systolic_top.sv */
// self-checking testbench for systolic_top, replays the vectors file and checks every result
`include "systolic_defs.svh"

module tb_systolic_top;

  localparam int N  = `ARRAY_SIZE;
  localparam int LW = `ARRAY_SIZE * `DWIDTH; // one packed lane vector

  logic               clk;
  logic               reset;
  logic               i_start;
  logic [1:0]         i_op;
  logic               i_valid;
  logic [LW-1:0]      i_a_lanes;
  logic [LW-1:0]      i_b_lanes;
  logic               o_done;
  logic [N*LW-1:0]    o_result;

  logic [1:0]         ops [$];
  logic [LW-1:0]      a_steps [$];   // N per test
  logic [LW-1:0]      b_steps [$];
  logic [`DWIDTH-1:0] exp_words [$]; // N*N per test in row-major order
  logic [31:0]        lfsr;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycle_count = 0;
  int                 cycle_limit = 16;

  systolic_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_op      (i_op),
    .i_valid   (i_valid),
    .i_a_lanes (i_a_lanes),
    .i_b_lanes (i_b_lanes),
    .o_done    (o_done),
    .o_result  (o_result)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, o_done never arrived", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // next hex token from the vectors file where comments run from # to end of line
  function automatic bit next_hex(input int fd, output logic [LW-1:0] value);
    string tok;
    string rest;
    int    code;
    value = '0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $sscanf(tok, "%h", value);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic load_vectors();
    int            fd;
    logic [LW-1:0] v;
    fd = $fopen("tests/systolic_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/systolic_vectors.txt");
      errors++;
    end else begin
      while (next_hex(fd, v)) begin
        ops.push_back(v[1:0]);
        for (int k = 0; k < N; k++) begin
          void'(next_hex(fd, v));
          a_steps.push_back(v);
        end
        for (int k = 0; k < N; k++) begin
          void'(next_hex(fd, v));
          b_steps.push_back(v);
        end
        for (int w = 0; w < N * N; w++) begin
          void'(next_hex(fd, v));
          exp_words.push_back(v[`DWIDTH-1:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_idle();
    checks++;
    if (o_done !== 1'b0 || o_result !== '0) begin
      errors++;
      $display("FAIL time %0t: o_done expected 0, got %b; o_result expected 0, got %h",
               $time, o_done, o_result);
    end
  endtask

  task automatic run_test(input int t);
    int                 latency;
    logic [`DWIDTH-1:0] got;
    @(negedge clk);
    i_start = 1'b1;
    i_op    = ops[t];
    for (int k = 0; k < N; k++) begin
      @(negedge clk);
      i_start   = 1'b0;
      i_valid   = 1'b1;
      i_a_lanes = a_steps[t*N+k];
      i_b_lanes = b_steps[t*N+k];
    end
    @(negedge clk); // first edge after the last step was sampled
    i_valid   = 1'b0;
    i_a_lanes = '0;
    i_b_lanes = '0;
    latency   = 0;
    while (!o_done) begin
      @(negedge clk);
      latency++;
    end
    checks++;
    if (latency != `DONE_LATENCY) begin
      errors++;
      $display("FAIL time %0t: o_done latency expected %0d, got %0d",
               $time, `DONE_LATENCY, latency);
    end
    for (int w = 0; w < N * N; w++) begin
      got = o_result[w*`DWIDTH +: `DWIDTH];
      checks++;
      if (got !== exp_words[t*N*N+w]) begin
        errors++;
        $display("FAIL time %0t: o_result C[%0d][%0d] expected %h, got %h",
                 $time, w / N, w % N, exp_words[t*N*N+w], got);
      end
    end
    @(negedge clk);
    checks++;
    if (o_done !== 1'b0) begin
      errors++;
      $display("FAIL time %0t: o_done one cycle after the pulse expected 0, got %b",
               $time, o_done);
    end
  endtask

  // zero to three idle cycles between operations from two lfsr bits
  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | lfsr[0];
    end
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    i_start   = 1'b0;
    i_op      = 2'b00;
    i_valid   = 1'b0;
    i_a_lanes = '0;
    i_b_lanes = '0;
    lfsr      = 32'h28cd5bc9;
    load_vectors();
    if (ops.size() == 0) begin
      errors++;
      $display("no tests found in the vectors file");
    end
    cycle_limit = 40 * ops.size() + 16 + 4; // a few extra for the idle check
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle();
    end
    for (int t = 0; t < ops.size(); t++) begin
      run_test(t);
      idle_gap();
    end
    $display("tests %0d, checks %0d, errors %0d", ops.size(), checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
